//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_idu
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/idu_assert.sv
`timescale 1ns/10ps

module idu_assert (
    input logic        clock,
    input logic        rst_n,
    input logic        inst_valid,
    input logic        inst_ready,
    input logic        dec_valid,
    input logic        dec_ready,
    input logic [5:0]  alu_op,
    input logic [2:0]  pc_sel,
    input logic        wen,
    input logic        wen_read,
    input logic        wen_csr,
    input logic        ecall,
    input logic [4:0]  rd,
    input logic [4:0]  rs1,
    input logic [4:0]  rs2,
    input logic [31:0] imm
);

    wire stalled = dec_valid && !dec_ready;

    a_reset_clear: assert property (@(posedge clock) !rst_n |=> !dec_valid)
        else $error("dec_valid high after a reset cycle");

    // Held record must not move
    a_hold: assert property (@(posedge clock) disable iff (!rst_n)
        stalled |=> dec_valid && $stable({alu_op, pc_sel, wen, wen_read, wen_csr,
                                          ecall, rd, rs1, rs2, imm}))
        else $error("decode record changed while stalled");

    // Room and nothing offered, so the latch empties
    a_drain: assert property (@(posedge clock) disable iff (!rst_n)
        inst_ready && !inst_valid |=> !dec_valid)
        else $error("dec_valid high with no instruction taken");

endmodule

bind idu_top idu_assert idu_assert_i (.*);

//--- bench/idu_patterns.hex
// inst alu_op pc_sel flags{wen,wen_read,wen_csr,ecall} rd rs1 rs2 imm
// register ops, immediates, branches, system
003100B3 09 6 C 01 02 03 00000003
407302B3 0A 6 C 05 06 07 00000407
003110B3 16 6 C 01 02 03 00000003
003120B3 17 6 C 01 02 03 00000003
003130B3 0D 6 C 01 02 03 00000003
003140B3 0C 6 C 01 02 03 00000003
003150B3 21 6 C 01 02 03 00000003
403150B3 22 6 C 01 02 03 00000403
003160B3 0B 6 C 01 02 03 00000003
003170B3 1E 6 C 01 02 03 00000003
FFF10093 00 6 C 01 02 1F FFFFFFFF
123451B7 02 6 8 03 08 03 12345000
80000217 01 6 8 04 00 00 80000000
FFDFF0EF 03 2 8 01 1F 1D FFFFFFFC
008280E7 03 1 8 01 05 08 00000008
FE712C23 05 6 4 18 02 07 FFFFFFF8
003202A3 1C 6 4 05 04 03 00000005
00208863 04 4 4 10 01 02 00000010
00209863 08 4 0 10 01 02 00000010
0020C863 13 4 4 10 01 02 00000010
0020D863 0E 4 0 10 01 02 00000010
0020E863 14 4 4 10 01 02 00000010
FE20FFE3 15 4 4 1F 01 02 FFFFFFFE
00000073 00 5 1 00 00 00 00000000
30200073 00 5 0 00 00 02 00000000
300110F3 24 6 E 01 02 00 00000000
341021F3 25 6 E 03 00 01 00000000
00C0A303 06 6 C 06 01 0C 0000000C

//--- bench/tb_idu.sv
`timescale 1ns/10ps

module tb_idu import idu_pkg::*; ();

    localparam int n_pat      = 28;
    localparam int words      = 8;   // inst, alu_op, pc_sel, flags, rd, rs1, rs2, imm
    localparam int reset_cyc  = 8;
    localparam int cycle_lim  = 4 * (2 * n_pat) + reset_cyc + 50;   // two streams

    logic                 clock;
    logic                 rst_n;
    logic [xlen-1:0]      inst;
    logic                 inst_valid;
    logic                 inst_ready;
    logic                 dec_valid;
    logic                 dec_ready;
    alu_op_e              alu_op;
    pc_sel_e              pc_sel;
    logic                 wen;
    logic                 wen_read;
    logic                 wen_csr;
    logic                 ecall;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [xlen-1:0]      imm;

    logic [31:0] pat_mem [0:n_pat*words-1];
    int          exp_q[$];
    int          drv_idx;
    bit          took;
    bit          took_prev;
    int          errors;
    int          consumed;
    int          cycles;
    logic [31:0] lfsr_state;

    idu_top idu_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic bit next_ready(input bit use_stalls);
        if (!use_stalls) return 1'b1;
        lfsr_state = lfsr_step(lfsr_state);
        return !lfsr_state[0];
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int idx);
        if (got !== exp) begin
            $display("** Error pattern %0d: %s got %h expected %h", idx, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_record();
        int idx;
        int b;
        if (exp_q.size() == 0) begin
            $display("Record came out of the DUT with no instruction pending");
            errors++;
        end else begin
            idx = exp_q.pop_front();
            b   = idx * words;
            check_field("alu_op",   32'(alu_op),   pat_mem[b+1], idx);
            check_field("pc_sel",   32'(pc_sel),   pat_mem[b+2], idx);
            check_field("wen",      32'(wen),      32'(pat_mem[b+3][3]), idx);
            check_field("wen_read", 32'(wen_read), 32'(pat_mem[b+3][2]), idx);
            check_field("wen_csr",  32'(wen_csr),  32'(pat_mem[b+3][1]), idx);
            check_field("ecall",    32'(ecall),    32'(pat_mem[b+3][0]), idx);
            check_field("rd",       32'(rd),       pat_mem[b+4], idx);
            check_field("rs1",      32'(rs1),      pat_mem[b+5], idx);
            check_field("rs2",      32'(rs2),      pat_mem[b+6], idx);
            check_field("imm",      imm,           pat_mem[b+7], idx);
            consumed++;
        end
    endtask

    // Inputs move on the falling edge, so everything here is settled
    always @(posedge clock) begin
        if (rst_n) begin
            if (took_prev && !dec_valid) begin
                $display("dec_valid did not rise one cycle after an accepted instruction");
                errors++;
            end
            // Room while nothing is pending or the sink takes the held record
            check_field("inst_ready", 32'(inst_ready),
                        32'((exp_q.size() == 0) || dec_ready), drv_idx);
            took      = inst_valid && inst_ready;
            took_prev = took;
            if (took) exp_q.push_back(drv_idx);
            if (dec_valid && dec_ready) compare_record();
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_lim) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic run_stream(input string name, input bit use_stalls);
        int sent;
        int err0;
        sent     = 0;
        err0     = errors;
        consumed = 0;
        took     = 1'b0;
        while (sent < n_pat) begin
            @(negedge clock);
            if (took) sent++;
            if (sent < n_pat) begin
                inst_valid = 1'b1;
                inst       = pat_mem[sent*words];
                drv_idx    = sent;
            end else begin
                inst_valid = 1'b0;
            end
            dec_ready = next_ready(use_stalls);
        end
        while (exp_q.size() != 0) begin
            @(negedge clock);
            dec_ready = next_ready(use_stalls);
        end
        @(negedge clock);
        dec_ready = 1'b1;
        if (consumed != n_pat) begin
            $display("%s: %0d records came out for %0d instructions", name, consumed, n_pat);
            errors++;
        end
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    initial begin
        int err0;
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        dec_ready  = 1'b1;
        drv_idx    = 0;
        took       = 1'b0;
        took_prev  = 1'b0;
        errors     = 0;
        cycles     = 0;
        lfsr_state = 32'h1b50408b;
        $readmemh("bench/idu_patterns.hex", pat_mem);

        repeat (reset_cyc) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        err0 = errors;
        check_field("dec_valid", 32'(dec_valid), 32'h0, -1);
        check_field("wen",       32'(wen),       32'h0, -1);
        check_field("wen_read",  32'(wen_read),  32'h0, -1);
        check_field("wen_csr",   32'(wen_csr),   32'h0, -1);
        check_field("ecall",     32'(ecall),     32'h0, -1);
        $display("test reset_state: %0d errors", errors - err0);

        run_stream("stream_no_stall", 1'b0);
        run_stream("stream_random_stall", 1'b1);

        $display("checks done, %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- logic/decode_latch.sv
`timescale 1ns/10ps

module decode_latch import idu_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    output logic                 inst_ready,
    output logic                 dec_valid,
    input  logic                 dec_ready,
    input  alu_op_e              alu_op_d,
    input  pc_sel_e              pc_sel_d,
    input  logic                 wen_d,
    input  logic                 wen_read_d,
    input  logic                 wen_csr_d,
    input  logic                 ecall_d,
    input  logic [reg_idx_w-1:0] rd_d,
    input  logic [reg_idx_w-1:0] rs1_d,
    input  logic [reg_idx_w-1:0] rs2_d,
    input  logic [xlen-1:0]      imm_d,
    output alu_op_e              alu_op,
    output pc_sel_e              pc_sel,
    output logic                 wen,
    output logic                 wen_read,
    output logic                 wen_csr,
    output logic                 ecall,
    output logic [reg_idx_w-1:0] rd,
    output logic [reg_idx_w-1:0] rs1,
    output logic [reg_idx_w-1:0] rs2,
    output logic [xlen-1:0]      imm
);

    logic take;

    // Room when empty or when the held record leaves this cycle
    assign inst_ready = !dec_valid || dec_ready;
    assign take       = inst_valid && inst_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            wen       <= 1'b0;
            wen_read  <= 1'b0;
            wen_csr   <= 1'b0;
            ecall     <= 1'b0;
        end else begin
            if (inst_ready) dec_valid <= inst_valid;   // refill or drain
            if (take) begin
                wen      <= wen_d;
                wen_read <= wen_read_d;
                wen_csr  <= wen_csr_d;
                ecall    <= ecall_d;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            alu_op <= alu_op_d;
            pc_sel <= pc_sel_d;
            rd     <= rd_d;
            rs1    <= rs1_d;
            rs2    <= rs2_d;
            imm    <= imm_d;
        end
    end

endmodule

//--- logic/idu_pkg.sv
package idu_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // ALU funct3, shared by register and immediate forms
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;   // srl/sra, split by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_jalr = 3'b000;

    // Loads and stores
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // System group
    localparam logic [2:0] f3_priv  = 3'b000;  // ecall, mret
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra, srai
    localparam logic [6:0] f7_mret = 7'b0011000;

    // Execute stage relies on this numbering
    typedef enum logic [5:0] {
        alu_addi  = 6'd0,   // also any unrecognised word
        alu_auipc = 6'd1,
        alu_lui   = 6'd2,
        alu_jump  = 6'd3,   // jal and jalr
        alu_beq   = 6'd4,
        alu_sw    = 6'd5,
        alu_lw    = 6'd6,
        alu_sltiu = 6'd7,
        alu_bne   = 6'd8,
        alu_add   = 6'd9,
        alu_sub   = 6'd10,
        alu_or    = 6'd11,
        alu_xor   = 6'd12,
        alu_sltu  = 6'd13,
        alu_bge   = 6'd14,
        alu_slli  = 6'd15,
        alu_andi  = 6'd16,
        alu_srli  = 6'd17,
        alu_slti  = 6'd18,
        alu_blt   = 6'd19,
        alu_bltu  = 6'd20,
        alu_bgeu  = 6'd21,
        alu_sll   = 6'd22,
        alu_slt   = 6'd23,
        alu_xori  = 6'd24,
        alu_ori   = 6'd25,
        alu_lbu   = 6'd26,
        alu_srai  = 6'd27,
        alu_sb    = 6'd28,
        alu_sh    = 6'd29,
        alu_and   = 6'd30,
        alu_lb    = 6'd31,
        alu_lh    = 6'd32,
        alu_srl   = 6'd33,
        alu_sra   = 6'd34,
        alu_lhu   = 6'd35,
        alu_csrrw = 6'd36,
        alu_csrrs = 6'd37
    } alu_op_e;

    typedef enum logic [2:0] {
        pc_jalr   = 3'd1,
        pc_jal    = 3'd2,
        pc_branch = 3'd4,
        pc_trap   = 3'd5,   // ecall and mret
        pc_seq    = 3'd6
    } pc_sel_e;

    typedef enum logic [2:0] {
        imm_i   = 3'd0,
        imm_u   = 3'd1,
        imm_j   = 3'd2,
        imm_s   = 3'd3,
        imm_b   = 3'd4,
        imm_sys = 3'd5
    } imm_fmt_e;

endpackage

//--- logic/idu_top.sv
`timescale 1ns/10ps

module idu_top import idu_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [xlen-1:0]      inst,
    input  logic                 inst_valid,
    output logic                 inst_ready,
    output logic                 dec_valid,
    input  logic                 dec_ready,
    output alu_op_e              alu_op,
    output pc_sel_e              pc_sel,
    output logic                 wen,
    output logic                 wen_read,
    output logic                 wen_csr,
    output logic                 ecall,
    output logic [reg_idx_w-1:0] rd,
    output logic [reg_idx_w-1:0] rs1,
    output logic [reg_idx_w-1:0] rs2,
    output logic [xlen-1:0]      imm
);

    // Combinational decode of the offered word
    alu_op_e              alu_op_c;
    pc_sel_e              pc_sel_c;
    logic                 wen_c;
    logic                 wen_read_c;
    logic                 wen_csr_c;
    logic                 ecall_c;
    logic [reg_idx_w-1:0] rd_c;
    logic [reg_idx_w-1:0] rs1_c;
    logic [reg_idx_w-1:0] rs2_c;
    logic [xlen-1:0]      imm_c;

    inst_classify inst_classify_i (
        .inst     (inst),
        .alu_op   (alu_op_c),
        .pc_sel   (pc_sel_c),
        .wen      (wen_c),
        .wen_read (wen_read_c),
        .wen_csr  (wen_csr_c),
        .ecall    (ecall_c),
        .rd       (rd_c),
        .rs1      (rs1_c),
        .rs2      (rs2_c)
    );

    imm_gen imm_gen_i (
        .inst (inst),
        .imm  (imm_c)
    );

    decode_latch decode_latch_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .alu_op_d   (alu_op_c),
        .pc_sel_d   (pc_sel_c),
        .wen_d      (wen_c),
        .wen_read_d (wen_read_c),
        .wen_csr_d  (wen_csr_c),
        .ecall_d    (ecall_c),
        .rd_d       (rd_c),
        .rs1_d      (rs1_c),
        .rs2_d      (rs2_c),
        .imm_d      (imm_c),
        .alu_op     (alu_op),
        .pc_sel     (pc_sel),
        .wen        (wen),
        .wen_read   (wen_read),
        .wen_csr    (wen_csr),
        .ecall      (ecall),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm)
    );

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/10ps

module imm_gen import idu_pkg::*; (
    input  logic [xlen-1:0] inst,
    output logic [xlen-1:0] imm
);

    imm_fmt_e fmt;

    // Format follows the major opcode alone
    always_comb begin
        case (inst[6:0])
            op_lui,
            op_auipc:  fmt = imm_u;
            op_jal:    fmt = imm_j;
            op_store:  fmt = imm_s;
            op_branch: fmt = imm_b;
            op_system: fmt = imm_sys;
            default:   fmt = imm_i;    // op-imm, loads, jalr
        endcase
    end

    always_comb begin
        case (fmt)
            imm_u: begin
                imm = {inst[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            imm_s: begin
                imm = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            imm_b: begin
                // Bit 0 is implied, offsets are even
                imm = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            imm_sys: begin
                imm = '0;               // CSR address not passed as data
            end
            default: begin
                imm = {{(xlen-12){inst[31]}}, inst[31:20]};
            end
        endcase
    end

endmodule

//--- logic/inst_classify.sv
`timescale 1ns/10ps

module inst_classify import idu_pkg::*; (
    input  logic [xlen-1:0]      inst,
    output alu_op_e              alu_op,
    output pc_sel_e              pc_sel,
    output logic                 wen,
    output logic                 wen_read,
    output logic                 wen_csr,
    output logic                 ecall,
    output logic [reg_idx_w-1:0] rd,
    output logic [reg_idx_w-1:0] rs1,
    output logic [reg_idx_w-1:0] rs2
);

    wire [6:0] opcode = inst[6:0];
    wire [2:0] funct3 = inst[14:12];
    wire [6:0] funct7 = inst[31:25];

    wire is_r   = (opcode == op_reg);
    wire is_i   = (opcode == op_imm);
    wire is_ld  = (opcode == op_load);
    wire is_st  = (opcode == op_store);
    wire is_br  = (opcode == op_branch);
    wire is_sys = (opcode == op_system);

    // Register-register
    wire is_add  = is_r & (funct3 == f3_add)  & (funct7 == f7_base);
    wire is_sub  = is_r & (funct3 == f3_add)  & (funct7 == f7_alt);
    wire is_sll  = is_r & (funct3 == f3_sll)  & (funct7 == f7_base);
    wire is_slt  = is_r & (funct3 == f3_slt)  & (funct7 == f7_base);
    wire is_sltu = is_r & (funct3 == f3_sltu) & (funct7 == f7_base);
    wire is_xor  = is_r & (funct3 == f3_xor)  & (funct7 == f7_base);
    wire is_srl  = is_r & (funct3 == f3_sr)   & (funct7 == f7_base);
    wire is_sra  = is_r & (funct3 == f3_sr)   & (funct7 == f7_alt);
    wire is_or   = is_r & (funct3 == f3_or)   & (funct7 == f7_base);
    wire is_and  = is_r & (funct3 == f3_and)  & (funct7 == f7_base);

    // Register-immediate, only the shifts look at funct7
    wire is_addi  = is_i & (funct3 == f3_add);
    wire is_slti  = is_i & (funct3 == f3_slt);
    wire is_sltiu = is_i & (funct3 == f3_sltu);
    wire is_xori  = is_i & (funct3 == f3_xor);
    wire is_ori   = is_i & (funct3 == f3_or);
    wire is_andi  = is_i & (funct3 == f3_and);
    wire is_slli  = is_i & (funct3 == f3_sll) & (funct7 == f7_base);
    wire is_srli  = is_i & (funct3 == f3_sr)  & (funct7 == f7_base);
    wire is_srai  = is_i & (funct3 == f3_sr)  & (funct7 == f7_alt);

    wire is_lb  = is_ld & (funct3 == f3_lb);
    wire is_lh  = is_ld & (funct3 == f3_lh);
    wire is_lw  = is_ld & (funct3 == f3_lw);
    wire is_lbu = is_ld & (funct3 == f3_lbu);
    wire is_lhu = is_ld & (funct3 == f3_lhu);
    wire is_sb  = is_st & (funct3 == f3_sb);
    wire is_sh  = is_st & (funct3 == f3_sh);
    wire is_sw  = is_st & (funct3 == f3_sw);

    wire is_beq  = is_br & (funct3 == f3_beq);
    wire is_bne  = is_br & (funct3 == f3_bne);
    wire is_blt  = is_br & (funct3 == f3_blt);
    wire is_bge  = is_br & (funct3 == f3_bge);
    wire is_bltu = is_br & (funct3 == f3_bltu);
    wire is_bgeu = is_br & (funct3 == f3_bgeu);
    wire any_br  = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

    wire is_lui   = (opcode == op_lui);
    wire is_auipc = (opcode == op_auipc);
    wire is_jal   = (opcode == op_jal);
    wire is_jalr  = (opcode == op_jalr) & (funct3 == f3_jalr);

    // ecall and mret differ only in funct7
    wire is_ecall = is_sys & (funct3 == f3_priv) & (funct7 == f7_base);
    wire is_mret  = is_sys & (funct3 == f3_priv) & (funct7 == f7_mret);
    wire is_csrrw = is_sys & (funct3 == f3_csrrw);
    wire is_csrrs = is_sys & (funct3 == f3_csrrs);

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    assign alu_op = is_auipc            ? alu_auipc :
                    is_lui              ? alu_lui   :
                    (is_jal | is_jalr)  ? alu_jump  :
                    is_beq              ? alu_beq   :
                    is_sw               ? alu_sw    :
                    is_lw               ? alu_lw    :
                    is_sltiu            ? alu_sltiu :
                    is_bne              ? alu_bne   :
                    is_add              ? alu_add   :
                    is_sub              ? alu_sub   :
                    is_or               ? alu_or    :
                    is_xor              ? alu_xor   :
                    is_sltu             ? alu_sltu  :
                    is_bge              ? alu_bge   :
                    is_slli             ? alu_slli  :
                    is_andi             ? alu_andi  :
                    is_srli             ? alu_srli  :
                    is_slti             ? alu_slti  :
                    is_blt              ? alu_blt   :
                    is_bltu             ? alu_bltu  :
                    is_bgeu             ? alu_bgeu  :
                    is_sll              ? alu_sll   :
                    is_slt              ? alu_slt   :
                    is_xori             ? alu_xori  :
                    is_ori              ? alu_ori   :
                    is_lbu              ? alu_lbu   :
                    is_srai             ? alu_srai  :
                    is_sb               ? alu_sb    :
                    is_sh               ? alu_sh    :
                    is_and              ? alu_and   :
                    is_lb               ? alu_lb    :
                    is_lh               ? alu_lh    :
                    is_srl              ? alu_srl   :
                    is_sra              ? alu_sra   :
                    is_lhu              ? alu_lhu   :
                    is_csrrw            ? alu_csrrw :
                    is_csrrs            ? alu_csrrs :
                                          alu_addi;   // addi and unknown words

    assign pc_sel = is_jalr                ? pc_jalr   :
                    is_jal                 ? pc_jal    :
                    any_br                 ? pc_branch :
                    (is_ecall | is_mret)   ? pc_trap   :
                                             pc_seq;

    assign wen = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi
               | is_slli | is_srli | is_srai
               | is_add | is_sub | is_sll | is_slt | is_sltu
               | is_xor | is_srl | is_sra | is_or | is_and
               | is_lb | is_lh | is_lw | is_lbu | is_lhu
               | is_lui | is_auipc | is_jal | is_jalr
               | is_csrrw | is_csrrs;

    // Reading set leaves out jalr, bne and bge
    assign wen_read = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi
                    | is_slli | is_srli | is_srai
                    | is_add | is_sub | is_sll | is_slt | is_sltu
                    | is_xor | is_srl | is_sra | is_or | is_and
                    | is_lb | is_lh | is_lw | is_lbu | is_lhu
                    | is_sb | is_sh | is_sw
                    | is_beq | is_blt | is_bltu | is_bgeu
                    | is_csrrw | is_csrrs;

    assign wen_csr = is_csrrw | is_csrrs;
    assign ecall   = is_ecall;

endmodule

//--- tb.f
logic/idu_pkg.sv
logic/inst_classify.sv
logic/imm_gen.sv
logic/decode_latch.sv
logic/idu_top.sv
bench/idu_assert.sv
bench/tb_idu.sv
